// File: design/box_drawer.sv
// ******************************
// box drawer
// writes a rectangle outline, starting at a frame start
// ******************************

`timescale 1ns/10ps

module box_drawer (
    input  logic                  clk_pix,
    input  logic                  reset,
    input  logic                  frame,
    input  logic                  draw_start,
    input  fb_pkg::fb_coord_t     x0,
    input  fb_pkg::fb_coord_t     y0,
    input  fb_pkg::fb_coord_t     x1,
    input  fb_pkg::fb_coord_t     y1,
    input  fb_pkg::colour_idx_t   colour,
    output logic                  busy,
    pixel_write_if.producer       wr
);

    typedef enum logic [2:0] {idle, armed, top, right, left, bottom} state_t;

    state_t state;

    // latched request
    fb_pkg::fb_coord_t   bx0, by0, bx1, by1;
    fb_pkg::colour_idx_t bcol;

    // pixel on the bus
    fb_pkg::fb_coord_t   cur_x, cur_y;

    logic accept;

    assign accept = wr.valid && wr.ready;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: if (draw_start) state <= armed;
                armed: if (frame) state <= top;  // wait so the frame does not tear
                top: if (accept && cur_x == bx1) state <= right;
                right: if (accept && cur_y == by1) state <= left;
                left: if (accept && cur_y == by1) state <= bottom;
                bottom: if (accept && cur_x == bx1) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // request latch and coordinate walk, moves only on an accepted write
    always_ff @(posedge clk_pix) begin
        case (state)
            idle: begin
                if (draw_start) begin
                    bx0  <= x0;
                    by0  <= y0;
                    bx1  <= x1;
                    by1  <= y1;
                    bcol <= colour;
                end
            end
            armed: begin
                cur_x <= bx0;
                cur_y <= by0;
            end
            top: begin
                if (accept && cur_x != bx1) cur_x <= cur_x + 1'b1;  // stops on the top right corner
            end
            right, left: begin
                if (accept) begin
                    if (cur_y != by1) begin
                        cur_y <= cur_y + 1'b1;
                    end else if (state == right) begin
                        cur_x <= bx0;
                        cur_y <= by0;
                    end else begin
                        cur_x <= bx0;  // bottom edge from the left
                    end
                end
            end
            bottom: begin
                if (accept && cur_x != bx1) cur_x <= cur_x + 1'b1;
            end
            default: ;
        endcase
    end

    assign busy     = (state != idle);
    assign wr.valid = (state != idle) && (state != armed);
    assign wr.x     = cur_x;
    assign wr.y     = cur_y;
    assign wr.cidx  = bcol;

endmodule

// File: design/display_timings.sv
// ******************************
// display timings
// 640x480 counters with syncs, data enable, frame start
// ******************************

`timescale 1ns/10ps

module display_timings (
    input  logic                  clk_pix,
    input  logic                  reset,
    output fb_pkg::screen_coord_t sx,
    output fb_pkg::screen_coord_t sy,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de,
    output logic                  frame
);

    // sync windows measured from the start of the line / frame
    localparam int hs_start = fb_pkg::h_res + fb_pkg::h_fp;       // 656
    localparam int hs_end   = hs_start + fb_pkg::h_sync - 1;      // 751
    localparam int vs_start = fb_pkg::v_res + fb_pkg::v_fp;       // 490
    localparam int vs_end   = vs_start + fb_pkg::v_sync - 1;      // 491

    logic line_end;
    logic frame_end;

    assign line_end  = (sx == fb_pkg::screen_coord_t'(fb_pkg::h_total - 1));
    assign frame_end = (sy == fb_pkg::screen_coord_t'(fb_pkg::v_total - 1));

    // horizontal count, every cycle
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
        end else if (line_end) begin
            sx <= '0;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // vertical count, once per line
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sy <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end
    end

    // negative syncs
    assign hsync = ~((sx >= hs_start) && (sx <= hs_end));
    assign vsync = ~((sy >= vs_start) && (sy <= vs_end));

    assign de    = (sx < fb_pkg::h_res) && (sy < fb_pkg::v_res);
    assign frame = (sx == '0) && (sy == '0);  // one cycle per frame

endmodule

// File: design/display_top.sv
// ******************************
// display top
// timing, box drawer, framebuffer and scanout
// ******************************

`timescale 1ns/10ps

module display_top (
    input  logic                clk_pix,
    input  logic                reset,
    input  logic                draw_start,
    input  fb_pkg::fb_coord_t   x0,
    input  fb_pkg::fb_coord_t   y0,
    input  fb_pkg::fb_coord_t   x1,
    input  fb_pkg::fb_coord_t   y1,
    input  fb_pkg::colour_idx_t colour,
    output logic                busy,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic                vga_de,   // de delayed to match the colour
    output logic [3:0]          vga_r,
    output logic [3:0]          vga_g,
    output logic [3:0]          vga_b
);

    fb_pkg::screen_coord_t sx, sy;
    logic                  hsync, vsync, de, frame;
    fb_pkg::fb_addr_t      rd_addr;
    fb_pkg::colour_idx_t   rd_data;
    fb_pkg::rgb_t          vga_rgb;

    pixel_write_if wr_bus ();

    display_timings timings0 (
        .clk_pix (clk_pix),
        .reset   (reset),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame)
    );

    box_drawer drawer0 (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .frame      (frame),
        .draw_start (draw_start),
        .x0         (x0),
        .y0         (y0),
        .x1         (x1),
        .y1         (y1),
        .colour     (colour),
        .busy       (busy),
        .wr         (wr_bus.producer)
    );

    framebuffer fb0 (
        .clk_pix (clk_pix),
        .reset   (reset),
        .wr      (wr_bus.buffer),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    palette_scanout scan0 (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .sx        (sx),
        .sy        (sy),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_de    (vga_de),
        .vga_rgb   (vga_rgb)
    );

    assign vga_r = vga_rgb[11:8];
    assign vga_g = vga_rgb[7:4];
    assign vga_b = vga_rgb[3:0];

endmodule

// File: design/fb_pkg.sv
// ******************************
// framebuffer display package
// raster timings, buffer sizes, types and palette
// ******************************

package fb_pkg;

    // 640x480 raster, syncs active low
    localparam int h_res   = 640;
    localparam int h_fp    = 16;
    localparam int h_sync  = 96;
    localparam int h_bp    = 48;
    localparam int h_total = h_res + h_fp + h_sync + h_bp;  // 800

    localparam int v_res   = 480;
    localparam int v_fp    = 10;
    localparam int v_sync  = 2;
    localparam int v_bp    = 33;
    localparam int v_total = v_res + v_fp + v_sync + v_bp;  // 525

    // buffer shown at 4x on the screen
    localparam int fb_width  = 160;
    localparam int fb_height = 120;
    localparam int fb_scale  = 4;
    localparam int fb_depth  = fb_width * fb_height;  // 19200 words

    typedef logic [9:0]  screen_coord_t;
    typedef logic [7:0]  fb_coord_t;
    typedef logic [14:0] fb_addr_t;
    typedef logic [3:0]  colour_idx_t;
    typedef logic [11:0] rgb_t;  // r in [11:8], g in [7:4], b in [3:0]

    // fixed 16 colours, entry 0 must stay black
    localparam rgb_t palette [16] = '{
        12'h000, 12'h00a, 12'h0a0, 12'h0aa, 12'ha00, 12'ha0a, 12'ha50, 12'haaa,
        12'h555, 12'h55f, 12'h5f5, 12'h5ff, 12'hf55, 12'hf5f, 12'hff5, 12'hfff
    };

endpackage

// File: design/framebuffer.sv
// ******************************
// framebuffer
// frame memory with clear after reset
// ******************************

`timescale 1ns/10ps

module framebuffer (
    input  logic                clk_pix,
    input  logic                reset,
    pixel_write_if.buffer       wr,
    input  fb_pkg::fb_addr_t    rd_addr,
    output fb_pkg::colour_idx_t rd_data
);

    localparam fb_pkg::fb_addr_t last_addr = fb_pkg::fb_addr_t'(fb_pkg::fb_depth - 1);

    fb_pkg::colour_idx_t mem [fb_pkg::fb_depth];

    logic             clearing;  // clear owns the write port
    fb_pkg::fb_addr_t clr_addr;

    fb_pkg::fb_addr_t    wr_addr;
    logic                mem_we;
    fb_pkg::fb_addr_t    mem_addr;
    fb_pkg::colour_idx_t mem_data;

    // clear sequencer
    // runs once from reset, one word per cycle
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing) begin
            if (clr_addr == last_addr) begin
                clearing <= 1'b0;
            end
            clr_addr <= clr_addr + 1'b1;
        end
    end

    // back-pressure on the producer while clearing
    assign wr.ready = ~clearing;

    // row major, y * 160 + x
    assign wr_addr = fb_pkg::fb_addr_t'(wr.y * fb_pkg::fb_width + wr.x);

    // single write port, clear takes priority
    always_comb begin
        if (clearing) begin
            mem_we   = 1'b1;
            mem_addr = clr_addr;
            mem_data = '0;  // palette black
        end else begin
            mem_we   = wr.valid && wr.ready;
            mem_addr = wr_addr;
            mem_data = wr.cidx;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_data;
        end
    end

    // registered read
    // same-address write in this cycle gives the old word
    always_ff @(posedge clk_pix) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: design/palette_scanout.sv
// ******************************
// palette scanout
// reads the buffer, maps index to colour, delays syncs
// ******************************

`timescale 1ns/10ps

module palette_scanout (
    input  logic                  clk_pix,
    input  logic                  reset,
    input  fb_pkg::screen_coord_t sx,
    input  fb_pkg::screen_coord_t sy,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  de,
    output fb_pkg::fb_addr_t      rd_addr,
    input  fb_pkg::colour_idx_t   rd_data,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output logic                  vga_de,
    output fb_pkg::rgb_t          vga_rgb
);

    fb_pkg::fb_coord_t fx, fy;  // scaled-down position

    logic hsync_p1, vsync_p1, de_p1;

    assign fx = fb_pkg::fb_coord_t'(sx / fb_pkg::fb_scale);
    assign fy = fb_pkg::fb_coord_t'(sy / fb_pkg::fb_scale);

    // address 0 in blanking, keeps the index in range
    always_comb begin
        if (de) begin
            rd_addr = fb_pkg::fb_addr_t'(fy * fb_pkg::fb_width + fx);
        end else begin
            rd_addr = '0;
        end
    end

    // stage 1 lines up with the memory read
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_p1 <= 1'b1;
            vsync_p1 <= 1'b1;
            de_p1    <= 1'b0;
        end else begin
            hsync_p1 <= hsync;
            vsync_p1 <= vsync;
            de_p1    <= de;
        end
    end

    // stage 2 palette lookup and output registers
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_hsync <= 1'b1;  // idle high
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            vga_rgb   <= '0;
        end else begin
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_de    <= de_p1;
            vga_rgb   <= de_p1 ? fb_pkg::palette[rd_data] : '0;  // blank outside active
        end
    end

endmodule

// File: design/pixel_write_if.sv
// ******************************
// pixel write bus
// valid/ready transfer of one framebuffer pixel
// ******************************

`timescale 1ns/10ps

interface pixel_write_if;

    logic                valid;  // producer has a pixel
    logic                ready;  // buffer can take it
    fb_pkg::fb_coord_t   x;
    fb_pkg::fb_coord_t   y;
    fb_pkg::colour_idx_t cidx;

    // x, y and cidx held while valid is waiting on ready
    modport producer (
        output valid, x, y, cidx,
        input  ready
    );

    modport buffer (
        input  valid, x, y, cidx,
        output ready
    );

endinterface

// File: run_sim.sh
#!/bin/bash
# build the display testbench with Verilator, run it, then check the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_display_top --Mdir obj_dir -o sim_tb \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 && echo "simulator exited normally" || echo "simulator exited with error"
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0

// File: testbench/tb_display_top.sv
// ******************************
// display top testbench
// reference frame model and output checks
// ******************************

`timescale 1ns/10ps

module tb_display_top;

    localparam int hs_first   = 656;  // sync windows of the 640x480 mode
    localparam int hs_last    = 751;
    localparam int vs_first   = 490;
    localparam int vs_last    = 491;
    localparam int frame_len  = fb_pkg::h_total * fb_pkg::v_total;
    localparam int busy_limit = 2 * frame_len;  // one frame of waiting plus the walk

    logic                clk_pix;
    logic                reset;
    logic                draw_start;
    fb_pkg::fb_coord_t   x0, y0, x1, y1;
    fb_pkg::colour_idx_t colour;
    logic                busy;
    logic                vga_hsync, vga_vsync, vga_de;
    logic [3:0]          vga_r, vga_g, vga_b;

    logic [3:0] model [fb_pkg::fb_width][fb_pkg::fb_height];  // expected indices
    int         tb_sx, tb_sy;
    int         cyc;  // edges since reset, stops at the clear length
    logic       p1_valid, p2_valid, p1_ok, p2_ok;
    int         p1_x, p1_y, p2_x, p2_y;
    logic [3:0] p1_idx, p2_idx;
    string      test_name;

    logic         exp_hsync, exp_vsync, exp_de;
    fb_pkg::rgb_t exp_rgb, act_rgb;

    display_top dut0 (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .draw_start (draw_start),
        .x0         (x0),
        .y0         (y0),
        .x1         (x1),
        .y1         (y1),
        .colour     (colour),
        .busy       (busy),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_de     (vga_de),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b)
    );

    always #50 clk_pix = ~clk_pix;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // own raster, two-cycle delay line and frame model
    always @(posedge clk_pix) begin
        int fx;
        int fy;
        fx = tb_sx / fb_pkg::fb_scale;
        fy = tb_sy / fb_pkg::fb_scale;
        if (reset) begin
            tb_sx    <= 0;
            tb_sy    <= 0;
            cyc      <= 0;
            p1_valid <= 1'b0;
            p2_valid <= 1'b0;
            for (int i = 0; i < fb_pkg::fb_width; i++) begin
                for (int j = 0; j < fb_pkg::fb_height; j++) begin
                    model[i][j] = 4'h0;
                end
            end
        end else begin
            if (tb_sx == fb_pkg::h_total - 1) begin
                tb_sx <= 0;
                tb_sy <= (tb_sy == fb_pkg::v_total - 1) ? 0 : tb_sy + 1;
            end else begin
                tb_sx <= tb_sx + 1;
            end
            if (cyc < fb_pkg::fb_depth) cyc <= cyc + 1;
            p1_valid <= 1'b1;
            p1_x     <= tb_sx;
            p1_y     <= tb_sy;
            p1_ok    <= (cyc >= fb_pkg::fb_depth) && !busy;  // memory settled
            p1_idx   <= (fx < fb_pkg::fb_width && fy < fb_pkg::fb_height) ? model[fx][fy] : 4'h0;
            p2_valid <= p1_valid;
            p2_x     <= p1_x;
            p2_y     <= p1_y;
            p2_ok    <= p1_ok;
            p2_idx   <= p1_idx;
            // accepted draw, outline enters the model after this edge's read
            if (draw_start && !busy) begin
                for (int i = int'(x0); i <= int'(x1); i++) begin
                    model[i][y0] = colour;
                    model[i][y1] = colour;
                end
                for (int j = int'(y0); j <= int'(y1); j++) begin
                    model[x0][j] = colour;
                    model[x1][j] = colour;
                end
            end
        end
    end

    assign exp_hsync = !(p2_x >= hs_first && p2_x <= hs_last);
    assign exp_vsync = !(p2_y >= vs_first && p2_y <= vs_last);
    assign exp_de    = (p2_x < fb_pkg::h_res) && (p2_y < fb_pkg::v_res);
    assign exp_rgb   = exp_de ? fb_pkg::palette[p2_idx] : 12'h000;
    assign act_rgb   = {vga_r, vga_g, vga_b};

    hsync_chk: assert property (@(posedge clk_pix) reset || !p2_valid || vga_hsync == exp_hsync)
        else stop_with_error($sformatf("Mismatch sync_timing hsync: expected %0b, actual %0b x=%0d",
            $sampled(exp_hsync), $sampled(vga_hsync), $sampled(p2_x)));

    vsync_chk: assert property (@(posedge clk_pix) reset || !p2_valid || vga_vsync == exp_vsync)
        else stop_with_error($sformatf("Mismatch sync_timing vsync: expected %0b, actual %0b y=%0d",
            $sampled(exp_vsync), $sampled(vga_vsync), $sampled(p2_y)));

    de_chk: assert property (@(posedge clk_pix) reset || !p2_valid || vga_de == exp_de)
        else stop_with_error($sformatf("Mismatch sync_timing de: expected %0b, actual %0b",
            $sampled(exp_de), $sampled(vga_de)));

    blank_chk: assert property (@(posedge clk_pix) reset || vga_de || act_rgb == 12'h000)
        else stop_with_error($sformatf("Mismatch blanking: expected 000, actual %03h",
            $sampled(act_rgb)));

    // write port held off for exactly the clear
    clear_chk: assert property (@(posedge clk_pix)
            reset || dut0.wr_bus.ready == (cyc >= fb_pkg::fb_depth))
        else stop_with_error($sformatf("Mismatch clear_ready: expected %0b, actual %0b",
            $sampled(cyc >= fb_pkg::fb_depth), $sampled(dut0.wr_bus.ready)));

    pixel_chk: assert property (@(posedge clk_pix)
            reset || !p2_valid || !p2_ok || !exp_de || act_rgb == exp_rgb)
        else stop_with_error($sformatf("Mismatch %s: expected %03h, actual %03h at x=%0d y=%0d",
            test_name, $sampled(exp_rgb), $sampled(act_rgb), $sampled(p2_x), $sampled(p2_y)));

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic draw_box(input int ax, input int ay, input int bx, input int by, input int c);
        x0         = fb_pkg::fb_coord_t'(ax);
        y0         = fb_pkg::fb_coord_t'(ay);
        x1         = fb_pkg::fb_coord_t'(bx);
        y1         = fb_pkg::fb_coord_t'(by);
        colour     = fb_pkg::colour_idx_t'(c);
        draw_start = 1'b1;
        @(posedge clk_pix);
        #1;
        draw_start = 1'b0;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (busy && n < busy_limit) begin
            @(posedge clk_pix);
            #1;
            n++;
        end
        if (busy) begin
            stop_with_error($sformatf("%s: busy still high after %0d cycles", what, busy_limit));
        end
    endtask

    task automatic show_frame();
        repeat (frame_len + 4) @(posedge clk_pix);
        #1;
    endtask

    initial begin
        int ax, ay, bx, by, c;
        clk_pix    = 1'b0;
        reset      = 1'b1;
        draw_start = 1'b0;
        x0         = '0;
        y0         = '0;
        x1         = '0;
        y1         = '0;
        colour     = '0;
        test_name  = "reset";
        void'($urandom(7));
        repeat (5) @(posedge clk_pix);
        #1;
        reset = 1'b0;

        // full border while the buffer is still clearing
        test_name = "cleared_frame";
        draw_box(0, 0, fb_pkg::fb_width - 1, fb_pkg::fb_height - 1, 3);
        assert (busy) else stop_with_error("busy did not rise for a draw during the clear");
        wait_idle(test_name);
        show_frame();

        test_name = "fixed_box";
        draw_box(10, 10, 149, 109, 5);
        assert (busy) else stop_with_error("busy did not rise for the fixed box draw");
        wait_idle(test_name);
        show_frame();

        test_name = "random_boxes";
        for (int k = 0; k < 3; k++) begin
            ax = int'($urandom % fb_pkg::fb_width);
            bx = int'($urandom % fb_pkg::fb_width);
            ay = int'($urandom % fb_pkg::fb_height);
            by = int'($urandom % fb_pkg::fb_height);
            c  = int'($urandom % 15) + 1;  // never black
            draw_box((ax < bx) ? ax : bx, (ay < by) ? ay : by,
                     (ax < bx) ? bx : ax, (ay < by) ? by : ay, c);
            assert (busy) else stop_with_error("busy did not rise for a random box draw");
            // request while busy, must leave no trace
            draw_box(0, 0, fb_pkg::fb_width - 1, fb_pkg::fb_height - 1, 15);
            wait_idle(test_name);
            show_frame();
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog.f
design/fb_pkg.sv
design/pixel_write_if.sv
design/display_timings.sv
design/box_drawer.sv
design/framebuffer.sv
design/palette_scanout.sv
design/display_top.sv
testbench/tb_display_top.sv
